// File: hw/cipher_pkg.sv
package cipher_pkg;

    // ======================================================================
    // Datapath geometry
    // ======================================================================

    localparam int unsigned word_w = 32;          // Data word width

    localparam int unsigned num_rounds = 12;      // Round stages after whitening

    // Whitening register plus one register per round
    localparam int unsigned pipe_latency = num_rounds + 1;

    // ======================================================================
    // Mixing constant
    // ======================================================================

    // XORed in by the whitening stage and added inside a round
    // whenever bit 0 of the stage input is set
    localparam logic [word_w-1:0] whiten_const = 32'h4cfe_df05;

endpackage

// File: hw/key_pkg.sv
package key_pkg;

    import cipher_pkg::*;

    // ======================================================================
    // Key layout
    // ======================================================================

    localparam int unsigned key_words = 4;                  // 32-bit words per key

    localparam int unsigned key_w = key_words * word_w;     // 128 bits

    localparam int unsigned key_idx_w = $clog2(key_words);  // Word index width

    // Same 128 bits seen two ways
    // flat  is the whole key, word 0 in bits 31:0
    // words is the per-word view used for writes and round selection
    typedef union packed {
        logic [key_w-1:0]                  flat;
        logic [key_words-1:0][word_w-1:0]  words;
    } key_t;

endpackage

// File: hw/key_store.sv
`timescale 1ns/1ps

module key_store
    import cipher_pkg::*;
    import key_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 key_wr,      // One-cycle word write strobe
    input  logic [key_idx_w-1:0] key_idx,
    input  logic [word_w-1:0]    key_word,
    input  logic                 key_commit,  // Shadow to active

    output key_t                 active_key
);

    // ======================================================================
    // Shadow key
    // ======================================================================

    key_t shadow_key;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shadow_key.flat <= '0;
        end else if (key_wr) begin
            shadow_key.words[key_idx] <= key_word;  // Only the indexed word moves
        end
    end

    // ======================================================================
    // Active key
    // ======================================================================

    // A write in the commit cycle lands in the shadow only, so the
    // active key picks up the value the shadow held before that edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_key.flat <= '0;
        end else if (key_commit) begin
            active_key <= shadow_key;
        end
    end

endmodule

// File: hw/cipher_round.sv
`timescale 1ns/1ps

module cipher_round
    import cipher_pkg::*;
#(
    parameter int unsigned round_no = 1     // 1 .. num_rounds, also the rotate amount
)
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              in_valid,
    input  logic [word_w-1:0] in_word,
    input  logic [word_w-1:0] round_key,

    output logic              out_valid,
    output logic [word_w-1:0] out_word
);

    logic [word_w-1:0] keyed;
    logic [word_w-1:0] mixed;
    logic [word_w-1:0] rotated;

    // ======================================================================
    // Round function
    // ======================================================================

    always_comb begin
        keyed   = in_word ^ round_key;
        mixed   = keyed + (in_word[0] ? whiten_const : '0);  // Add keyed on input LSB
        rotated = (mixed >> round_no) | (mixed << (word_w - round_no));
    end

    // ======================================================================
    // Stage registers
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_word <= rotated;    // Loads every cycle, valid tags it
    end

endmodule

// File: hw/cipher_pipe.sv
`timescale 1ns/1ps

module cipher_pipe
    import cipher_pkg::*;
    import key_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic              valid_in,     // Sampled every cycle
    input  logic [word_w-1:0] data_in,

    input  key_t              active_key,

    output logic              valid_out,
    output logic [word_w-1:0] data_out
);

    // Index 0 is the whitening register, index r is the output of round r
    logic [pipe_latency-1:0] stage_valid;
    logic [word_w-1:0]       stage_word [0:pipe_latency-1];

    // ======================================================================
    // Whitening stage
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stage_valid[0] <= 1'b0;
            stage_word[0]  <= '0;
        end else begin
            stage_valid[0] <= valid_in;
            stage_word[0]  <= data_in ^ whiten_const;
        end
    end

    // ======================================================================
    // Round chain
    // ======================================================================

    // Round r takes key word r mod 4, giving the order 1 2 3 0 repeating.
    // The rounds read the live active key, so a commit reaches every
    // item still in flight.
    for (genvar r = 1; r <= num_rounds; r++) begin : g_round
        logic [word_w-1:0] round_key;

        assign round_key = active_key.words[r % key_words];

        cipher_round #(
            .round_no (r)
        ) u_round (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (stage_valid[r-1]),
            .in_word   (stage_word[r-1]),
            .round_key (round_key),
            .out_valid (stage_valid[r]),
            .out_word  (stage_word[r])
        );
    end

    // ======================================================================
    // Output
    // ======================================================================

    assign valid_out = stage_valid[pipe_latency-1];   // Last round register
    assign data_out  = stage_word[pipe_latency-1];

endmodule

// File: hw/cipher_top.sv
`timescale 1ns/1ps

module cipher_top
    import cipher_pkg::*;
    import key_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    // Key loading
    input  logic                 key_wr,
    input  logic [key_idx_w-1:0] key_idx,
    input  logic [word_w-1:0]    key_word,
    input  logic                 key_commit,

    // Data path, no back-pressure
    input  logic                 valid_in,
    input  logic [word_w-1:0]    data_in,
    output logic                 valid_out,
    output logic [word_w-1:0]    data_out
);

    key_t active_key;       // Committed key seen by every round

    // ======================================================================
    // Key store and pipeline
    // ======================================================================

    key_store u_key_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_wr     (key_wr),
        .key_idx    (key_idx),
        .key_word   (key_word),
        .key_commit (key_commit),
        .active_key (active_key)
    );

    cipher_pipe u_pipe (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .data_in    (data_in),
        .active_key (active_key),
        .valid_out  (valid_out),
        .data_out   (data_out)
    );

endmodule

// File: verif/cipher_tb_model.svh
`ifndef CIPHER_TB_MODEL_SVH
`define CIPHER_TB_MODEL_SVH

// ======================================================================
// Reference model
// ======================================================================

localparam logic [31:0] model_const = 32'h4cfe_df05;   // Whitening and round add

function automatic logic [word_w-1:0] model_encrypt(input key_t key,
                                                    input logic [word_w-1:0] data);
    logic [word_w-1:0] w;
    logic [word_w-1:0] k;
    logic [word_w-1:0] keyed;
    logic [word_w-1:0] mixed;
    w = data ^ model_const;                             // Whitening
    for (int r = 1; r <= 12; r++) begin
        k     = key.flat[32*(r % 4) +: 32];             // Key word order 1 2 3 0
        keyed = w ^ k;
        mixed = keyed + (w[0] ? model_const : 32'h0);   // Add decided by stage input
        w     = (mixed >> r) | (mixed << (32 - r));     // Rotate right by round number
    end
    return w;
endfunction

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// ======================================================================
// Failure handling and compares
// ======================================================================

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Simulation stopped at %0t", $time);
endtask

task automatic check_word(input string name,
                         input logic [word_w-1:0] expected,
                         input logic [word_w-1:0] actual);
    if (actual !== expected) begin
        abort_run($sformatf("ERROR: %s expected %h actual %h at %0t",
                            name, expected, actual, $time));
    end
endtask

task automatic check_key(input key_t expected, input key_t actual);
    if (actual.flat !== expected.flat) begin
        abort_run($sformatf("ERROR: active_key expected %h actual %h at %0t",
                            expected.flat, actual.flat, $time));
    end
endtask

task automatic check_valid(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        abort_run($sformatf("ERROR: %s expected %h actual %h at %0t",
                            name, expected, actual, $time));
    end
endtask

`endif

// File: verif/cipher_tb.sv
`timescale 1ns/1ps

module cipher_tb
    import cipher_pkg::*;
    import key_pkg::*;
;

    localparam int lat_cycles  = 13;     // Accept edge to output edge
    localparam int wait_limit  = 100;
    localparam int num_vectors = 6;

    typedef struct packed {
        logic [127:0] key;
        int           burst_len;
        logic [15:0]  gap_mask;          // Bit i set: idle cycle after word i
        bit           use_rand;
        logic [31:0]  fixed_data;        // Base value, word i adds i
    } vector_t;

    logic                 clk;
    logic                 rst_n;
    logic                 key_wr;
    logic [key_idx_w-1:0] key_idx;
    logic [word_w-1:0]    key_word;
    logic                 key_commit;
    logic                 valid_in;
    logic [word_w-1:0]    data_in;
    logic                 valid_out;
    logic [word_w-1:0]    data_out;

    key_t              shadow_key;       // Mirror of the DUT shadow key
    key_t              committed_key;    // Key the rounds should be using
    logic [word_w-1:0] exp_word_q[$];
    int                exp_cycle_q[$];
    int                cycle_cnt = 0;
    int                max_in_flight = 0;
    logic [31:0]       rng_state = 32'd57700;
    logic              exp_valid;
    vector_t           vectors [num_vectors];

    `include "cipher_tb_model.svh"

    cipher_top u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_wr     (key_wr),
        .key_idx    (key_idx),
        .key_word   (key_word),
        .key_commit (key_commit),
        .valid_in   (valid_in),
        .data_in    (data_in),
        .valid_out  (valid_out),
        .data_out   (data_out)
    );

    // ======================================================================
    // Clock, cycle count and output checker
    // ======================================================================

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // Every word has a fixed arrival cycle, so gaps and latency are exact
    initial begin
        forever begin
            @(negedge clk);
            exp_valid = (exp_cycle_q.size() != 0) && (exp_cycle_q[0] == cycle_cnt);
            check_valid("valid_out", exp_valid, valid_out);
            if (valid_out) begin
                check_word("data_out", exp_word_q[0], data_out);
                void'(exp_word_q.pop_front());
                void'(exp_cycle_q.pop_front());
            end
        end
    end

    // ======================================================================
    // Driver tasks
    // ======================================================================

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;                                      // Inputs change clear of the edge
    endtask

    task automatic idle_cycle();
        valid_in = 1'b0;
        next_cycle();
    endtask

    task automatic send_word(input logic [word_w-1:0] data);
        valid_in = 1'b1;
        data_in  = data;
        exp_word_q.push_back(model_encrypt(committed_key, data));
        exp_cycle_q.push_back(cycle_cnt + lat_cycles);   // Last round loads 13 edges on
        if (exp_word_q.size() > max_in_flight) begin
            max_in_flight = exp_word_q.size();
        end
        next_cycle();
    endtask

    task automatic write_key_word(input logic [key_idx_w-1:0] idx,
                                  input logic [word_w-1:0] word);
        key_wr   = 1'b1;
        key_idx  = idx;
        key_word = word;
        shadow_key.words[idx] = word;
        next_cycle();
        key_wr = 1'b0;
    endtask

    task automatic commit_key();
        key_commit    = 1'b1;
        committed_key = shadow_key;
        next_cycle();
        key_commit = 1'b0;
        check_key(committed_key, u_dut.active_key);
    endtask

    task automatic load_key(input key_t key);
        for (int i = 0; i < key_words; i++) begin
            write_key_word(key_idx_w'(i), key.words[i]);
        end
        commit_key();
    endtask

    task automatic send_burst(input vector_t v);
        logic [word_w-1:0] data;
        for (int i = 0; i < v.burst_len; i++) begin
            if (v.use_rand) begin
                data = next_random();
            end else begin
                data = v.fixed_data + i;
            end
            send_word(data);
            if (v.gap_mask[i % 16]) begin
                idle_cycle();
            end
        end
        valid_in = 1'b0;
    endtask

    task automatic drain_pipe();
        int waited;
        valid_in = 1'b0;
        waited   = 0;
        while (exp_word_q.size() != 0 && waited < wait_limit) begin
            next_cycle();
            waited++;
        end
        if (exp_word_q.size() != 0) begin
            abort_run("Timeout: the pipeline did not drain within 100 cycles");
        end
    endtask

    // ======================================================================
    // Directed scenarios
    // ======================================================================

    task automatic key_update_test();
        key_t new_key;
        new_key.flat = 128'h7e57_0001_a5a5_5a5a_0bad_cafe_1357_2468;
        // Shadow writes while words are in flight, no commit
        for (int i = 0; i < 8; i++) begin
            if (i < key_words) begin
                key_wr   = 1'b1;
                key_idx  = key_idx_w'(i);
                key_word = new_key.words[i];
                shadow_key.words[i] = new_key.words[i];
            end else begin
                key_wr = 1'b0;
            end
            send_word(next_random());
        end
        key_wr = 1'b0;
        drain_pipe();
        check_key(committed_key, u_dut.active_key);   // Still the old key
        commit_key();
        for (int i = 0; i < 6; i++) send_word(next_random());
        drain_pipe();
        // Write and commit together, commit takes the older shadow
        key_wr        = 1'b1;
        key_idx       = 2'd2;
        key_word      = 32'hcafe_f00d;
        key_commit    = 1'b1;
        committed_key = shadow_key;
        shadow_key.words[2] = 32'hcafe_f00d;
        next_cycle();
        key_wr     = 1'b0;
        key_commit = 1'b0;
        check_key(committed_key, u_dut.active_key);
        for (int i = 0; i < 6; i++) send_word(next_random());
        drain_pipe();
        commit_key();                                 // Now picks up the late word
        for (int i = 0; i < 6; i++) send_word(next_random());
        drain_pipe();
    endtask

    task automatic reset_test();
        key_t post_key;
        post_key.flat = 128'h0f0f_0f0f_3c3c_3c3c_9876_5432_fedc_ba98;
        for (int i = 0; i < 6; i++) send_word(next_random());
        rst_n    = 1'b0;                  // Mid burst
        valid_in = 1'b0;
        exp_word_q.delete();
        exp_cycle_q.delete();
        shadow_key.flat    = '0;
        committed_key.flat = '0;
        repeat (3) next_cycle();
        rst_n = 1'b1;
        repeat (20) idle_cycle();         // Checker sees valid_out stay low
        check_key(committed_key, u_dut.active_key);
        load_key(post_key);
        for (int i = 0; i < 10; i++) send_word(next_random());
        drain_pipe();
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        rst_n              = 1'b0;
        key_wr             = 1'b0;
        key_idx            = '0;
        key_word           = '0;
        key_commit         = 1'b0;
        valid_in           = 1'b0;
        data_in            = '0;
        shadow_key.flat    = '0;
        committed_key.flat = '0;

        vectors[0] = '{128'h0, 1, 16'h0000, 1'b0, 32'h0000_0000};
        vectors[1] = '{128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0, 1, 16'h0000, 1'b0,
                       32'hdead_beef};
        vectors[2] = '{128'h01234567_89abcdef_fedcba98_76543210, 30, 16'h0000, 1'b1,
                       32'h0};
        vectors[3] = '{128'hffffffff_00000000_aaaaaaaa_55555555, 24, 16'h2916, 1'b1,
                       32'h0};
        vectors[4] = '{128'h13579bdf_2468ace0_0badf00d_c0ffee11, 16, 16'haaaa, 1'b0,
                       32'h1000_0000};
        vectors[5] = '{{4{32'hffff_ffff}}, 1, 16'h0000, 1'b0, 32'hffff_ffff};

        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();

        for (int n = 0; n < num_vectors; n++) begin
            load_key(vectors[n].key);
            send_burst(vectors[n]);
            drain_pipe();
        end
        if (max_in_flight < lat_cycles) begin
            abort_run("The pipeline never held 13 words in flight");
        end

        key_update_test();
        reset_test();
        repeat (3) idle_cycle();

        $display("Test passed");
        $finish;
    end

endmodule

// File: list.f
+incdir+verif
hw/cipher_pkg.sv
hw/key_pkg.sv
hw/key_store.sv
hw/cipher_round.sv
hw/cipher_pipe.sv
hw/cipher_top.sv
verif/cipher_tb.sv
